/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path width.
`define RV_XLEN 64

// data RAM size in 64-bit words.
`define RV_DMEM_WORDS 256

// word index width, log2 of RV_DMEM_WORDS.
`define RV_DMEM_AW 8

`endif

/* rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef struct packed {
        logic [31:0]         pc;
        logic [31:0]         inst;
        logic [2:0]          funct3;
        alu_op_e             alu_op;
        logic [4:0]          rd;
        logic                rd_w_en;
        logic [`RV_XLEN-1:0] x_rs1;
        logic [`RV_XLEN-1:0] x_rs2;
        logic [`RV_XLEN-1:0] imm;
        logic                use_imm;     // imm replaces x_rs2 as operand b.
        logic                inst_load;
        logic                inst_store;
        logic                inst_system_ebreak;
    } issue_t;

    typedef struct packed {
        logic [31:0]         pc;
        logic [31:0]         inst;
        logic [2:0]          funct3;
        logic [4:0]          rd;
        logic                rd_idx_0;
        logic                rd_w_en;
        logic [`RV_XLEN-1:0] x_rs2;       // store data.
        logic [`RV_XLEN-1:0] exu_result;  // alu result or memory address.
        logic                inst_load;
        logic                inst_store;
        logic                inst_system_ebreak;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0]         pc;
        logic [4:0]          rd;
        logic                rd_w_en;
        logic [`RV_XLEN-1:0] rd_data;
        logic                inst_system_ebreak;
    } mem_wb_t;

endpackage

/* pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     in_ready,
    output logic     out_valid,
    output logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    assign out_ready = in_ready & ~stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (out_ready) begin
            valid_q <= in_valid;  // empties when nothing comes in.
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && out_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

/* exec_unit.sv */
`include "rv_consts.svh"

module exec_unit (
    input  rv_pkg::issue_t  issue,
    output rv_pkg::ex_mem_t result
);

    localparam int SHW = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0] op_b;
    logic [SHW-1:0]      shamt;
    logic [`RV_XLEN-1:0] alu_out;
    logic [`RV_XLEN-1:0] agu_out;
    logic                mem_op;

    assign op_b    = issue.use_imm ? issue.imm : issue.x_rs2;
    assign shamt   = op_b[SHW-1:0];  // low bits only, as in rv64.
    assign agu_out = issue.x_rs1 + issue.imm;
    assign mem_op  = issue.inst_load | issue.inst_store;

    always_comb begin
        case (issue.alu_op)
            rv_pkg::ALU_ADD: begin
                alu_out = issue.x_rs1 + op_b;
            end
            rv_pkg::ALU_SUB: begin
                alu_out = issue.x_rs1 - op_b;
            end
            rv_pkg::ALU_AND: begin
                alu_out = issue.x_rs1 & op_b;
            end
            rv_pkg::ALU_OR: begin
                alu_out = issue.x_rs1 | op_b;
            end
            rv_pkg::ALU_XOR: begin
                alu_out = issue.x_rs1 ^ op_b;
            end
            rv_pkg::ALU_SLL: begin
                alu_out = issue.x_rs1 << shamt;
            end
            rv_pkg::ALU_SRL: begin
                alu_out = issue.x_rs1 >> shamt;
            end
            rv_pkg::ALU_SRA: begin
                alu_out = $signed(issue.x_rs1) >>> shamt;
            end
            rv_pkg::ALU_SLT: begin
                alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(issue.x_rs1) < $signed(op_b)};
            end
            rv_pkg::ALU_SLTU: begin
                alu_out = {{(`RV_XLEN-1){1'b0}}, issue.x_rs1 < op_b};
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

    always_comb begin
        result.pc                 = issue.pc;
        result.inst               = issue.inst;
        result.funct3             = issue.funct3;
        result.rd                 = issue.rd;
        result.rd_idx_0           = (issue.rd == 5'd0);
        result.rd_w_en            = issue.rd_w_en;
        result.x_rs2              = issue.x_rs2;
        result.exu_result         = mem_op ? agu_out : alu_out;  // address for ld/st.
        result.inst_load          = issue.inst_load;
        result.inst_store         = issue.inst_store;
        result.inst_system_ebreak = issue.inst_system_ebreak;
    end

endmodule

/* mem_stage.sv */
`include "rv_consts.svh"

module mem_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  rv_pkg::ex_mem_t in_data,
    input  logic            advance,
    output logic            mem_busy,
    output rv_pkg::mem_wb_t wb_data
);

    logic [`RV_XLEN-1:0]    dmem [`RV_DMEM_WORDS];
    logic [`RV_DMEM_AW-1:0] word_idx;
    logic [2:0]             byte_off;
    logic [7:0]             byte_en;
    logic [`RV_XLEN-1:0]    st_data;
    logic [`RV_XLEN-1:0]    rd_word;
    logic [`RV_XLEN-1:0]    ld_shift;
    logic [`RV_XLEN-1:0]    ld_data;
    logic                   ld_unsigned;
    logic                   wait_q;
    logic                   load_go;
    logic                   store_go;

    assign word_idx    = in_data.exu_result[`RV_DMEM_AW+2:3];
    assign byte_off    = in_data.exu_result[2:0];
    assign ld_unsigned = in_data.funct3[2];

    assign load_go  = in_valid & in_data.inst_load & ~wait_q;    // first cycle of a load.
    assign store_go = in_valid & in_data.inst_store & advance;  // store leaves ex/mem.
    assign mem_busy = load_go;

    always_comb begin
        case (in_data.funct3[1:0])
            2'b00:   byte_en = 8'b0000_0001 << byte_off;
            2'b01:   byte_en = 8'b0000_0011 << byte_off;
            2'b10:   byte_en = 8'b0000_1111 << byte_off;
            default: byte_en = 8'b1111_1111;
        endcase
    end

    assign st_data = in_data.x_rs2 << {byte_off, 3'b000};

    always_ff @(posedge clk) begin
        if (store_go) begin
            for (int i = 0; i < 8; i++) begin
                if (byte_en[i]) begin
                    dmem[word_idx][i*8 +: 8] <= st_data[i*8 +: 8];
                end
            end
        end
        if (load_go) begin
            rd_word <= dmem[word_idx];
        end
    end

    // set by the read, cleared when the load moves on.
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_q <= 1'b0;
        end else if (load_go) begin
            wait_q <= 1'b1;
        end else if (in_valid && advance) begin
            wait_q <= 1'b0;
        end
    end

    assign ld_shift = rd_word >> {byte_off, 3'b000};

    always_comb begin
        case (in_data.funct3[1:0])
            2'b00: begin
                ld_data = {{(`RV_XLEN-8){~ld_unsigned & ld_shift[7]}}, ld_shift[7:0]};
            end
            2'b01: begin
                ld_data = {{(`RV_XLEN-16){~ld_unsigned & ld_shift[15]}}, ld_shift[15:0]};
            end
            2'b10: begin
                ld_data = {{(`RV_XLEN-32){~ld_unsigned & ld_shift[31]}}, ld_shift[31:0]};
            end
            default: begin
                ld_data = ld_shift;
            end
        endcase
    end

    always_comb begin
        wb_data.pc                 = in_data.pc;
        wb_data.rd                 = in_data.rd;
        wb_data.rd_w_en            = in_valid & in_data.rd_w_en & ~in_data.rd_idx_0;
        wb_data.rd_data            = in_data.inst_load ? ld_data : in_data.exu_result;
        wb_data.inst_system_ebreak = in_valid & in_data.inst_system_ebreak;
    end

endmodule

/* rv_backend.sv */
module rv_backend (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_valid,
    input  rv_pkg::issue_t  issue,
    output logic            issue_ready,
    output logic            retire_valid,
    output rv_pkg::mem_wb_t retire,
    input  logic            retire_ready
);

    rv_pkg::ex_mem_t ex_result;
    rv_pkg::ex_mem_t ex_mem_q;
    logic            ex_mem_valid;
    logic            mem_busy;
    rv_pkg::mem_wb_t wb_next;
    logic            wb_valid;
    logic            wb_ready;

    assign wb_valid = ex_mem_valid & ~mem_busy;  // no load data yet.

    exec_unit u_exec_unit (
        .issue  (issue),
        .result (ex_result)
    );

    pipe_reg #(
        .payload_t (rv_pkg::ex_mem_t)
    ) u_ex_mem (
        .clk       (clk),
        .rst       (rst),
        .stall     (mem_busy),
        .in_valid  (issue_valid),
        .in_data   (ex_result),
        .in_ready  (wb_ready),
        .out_valid (ex_mem_valid),
        .out_ready (issue_ready),
        .out_data  (ex_mem_q)
    );

    mem_stage u_mem_stage (
        .clk      (clk),
        .rst      (rst),
        .in_valid (ex_mem_valid),
        .in_data  (ex_mem_q),
        .advance  (wb_ready),
        .mem_busy (mem_busy),
        .wb_data  (wb_next)
    );

    pipe_reg #(
        .payload_t (rv_pkg::mem_wb_t)
    ) u_mem_wb (
        .clk       (clk),
        .rst       (rst),
        .stall     (1'b0),
        .in_valid  (wb_valid),
        .in_data   (wb_next),
        .in_ready  (retire_ready),
        .out_valid (retire_valid),
        .out_ready (wb_ready),
        .out_data  (retire)
    );

endmodule

/* tb_rv_backend_assertions.sv */
module tb_rv_backend_assertions (
    input logic            clk,
    input logic            rst,
    input logic            issue_ready,
    input logic            mem_busy,
    input logic            retire_valid,
    input logic            retire_ready,
    input rv_pkg::mem_wb_t retire
);

    // pipeline is empty right after a reset cycle.
    assert property (@(posedge clk) rst |=> !retire_valid)
        else $error("retire_valid high in the cycle after reset");

    assert property (@(posedge clk) disable iff (rst)
        mem_busy |-> !issue_ready ##1 !mem_busy)
        else $error("issue_ready high or load busy longer than one cycle");

    assert property (@(posedge clk) disable iff (rst)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire))
        else $error("retire record changed while stalled");  // held until taken.

endmodule

bind rv_backend tb_rv_backend_assertions u_assertions (
    .clk          (clk),
    .rst          (rst),
    .issue_ready  (issue_ready),
    .mem_busy     (mem_busy),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire)
);

/* tb_rv_backend.sv */
`include "rv_consts.svh"

module tb_rv_backend;

    logic                clk;
    logic                rst;
    logic                issue_valid;
    rv_pkg::issue_t      issue;
    logic                issue_ready;
    logic                retire_valid;
    rv_pkg::mem_wb_t     retire;
    logic                retire_ready;
    logic [`RV_XLEN-1:0] model_ram [`RV_DMEM_WORDS];
    rv_pkg::mem_wb_t     exp_q [$];
    rv_pkg::mem_wb_t     exp_rec;
    int                  seed;
    int                  ready_seed;
    int                  issued;
    int                  cycles;
    logic                bp_mode;

    rv_backend dut (.*);

    always #20 clk = ~clk;

    function automatic rv_pkg::mem_wb_t ref_model(rv_pkg::issue_t p);
        rv_pkg::mem_wb_t     r;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] word;
        logic [2:0]          off;
        int                  n;
        b    = p.use_imm ? p.imm : p.x_rs2;
        addr = p.x_rs1 + p.imm;
        off  = addr[2:0];
        n    = 1 << p.funct3[1:0];  // access size in bytes.
        r = '{pc: p.pc, rd: p.rd, rd_w_en: p.rd_w_en && p.rd != 5'd0,
              rd_data: addr, inst_system_ebreak: p.inst_system_ebreak};
        if (p.inst_load) begin
            word = model_ram[addr[`RV_DMEM_AW+2:3]] >> (8 * off);
            for (int i = 0; i < 8; i++) begin
                r.rd_data[i*8 +: 8] = (i < n) ? word[i*8 +: 8] :
                    {8{~p.funct3[2] & word[8*n-1]}};  // sign or zero fill.
            end
        end else if (p.inst_store) begin
            for (int i = 0; i < n; i++) begin
                model_ram[addr[`RV_DMEM_AW+2:3]][(off + i)*8 +: 8] = p.x_rs2[i*8 +: 8];
            end
        end else begin
            case (p.alu_op)
                rv_pkg::ALU_ADD:  r.rd_data = p.x_rs1 + b;
                rv_pkg::ALU_SUB:  r.rd_data = p.x_rs1 - b;
                rv_pkg::ALU_AND:  r.rd_data = p.x_rs1 & b;
                rv_pkg::ALU_OR:   r.rd_data = p.x_rs1 | b;
                rv_pkg::ALU_XOR:  r.rd_data = p.x_rs1 ^ b;
                rv_pkg::ALU_SLL:  r.rd_data = p.x_rs1 << b[5:0];
                rv_pkg::ALU_SRL:  r.rd_data = p.x_rs1 >> b[5:0];
                rv_pkg::ALU_SRA:  r.rd_data = $signed(p.x_rs1) >>> b[5:0];
                rv_pkg::ALU_SLT:  r.rd_data = ($signed(p.x_rs1) < $signed(b)) ? 64'd1 : 64'd0;
                default:          r.rd_data = (p.x_rs1 < b) ? 64'd1 : 64'd0;
            endcase
        end
        return r;
    endfunction

    task automatic compare_field(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: retire.%s = %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "retire record mismatch");
        end
    endtask

    task automatic check_retire(rv_pkg::mem_wb_t got, rv_pkg::mem_wb_t exp);
        compare_field("pc", 64'(got.pc), 64'(exp.pc));
        compare_field("rd", 64'(got.rd), 64'(exp.rd));
        compare_field("rd_w_en", 64'(got.rd_w_en), 64'(exp.rd_w_en));
        compare_field("rd_data", got.rd_data, exp.rd_data);
        compare_field("inst_system_ebreak", 64'(got.inst_system_ebreak),
                      64'(exp.inst_system_ebreak));
    endtask

    function automatic rv_pkg::issue_t rand_issue();
        rv_pkg::issue_t p;
        p         = '0;
        p.pc      = $random(seed);
        p.inst    = $random(seed);
        p.funct3  = 3'($random(seed));
        p.alu_op  = rv_pkg::alu_op_e'({$random(seed)} % 10);
        p.rd      = 5'(1 + {$random(seed)} % 31);
        p.rd_w_en = 1'b1;
        p.x_rs1   = {$random(seed), $random(seed)};
        p.x_rs2   = {$random(seed), $random(seed)};
        p.imm     = {$random(seed), $random(seed)};
        p.use_imm = 1'($random(seed));
        return p;
    endfunction

    // random aligned offset inside word w.
    function automatic rv_pkg::issue_t mem_access(logic store, logic [2:0] f3, int w);
        rv_pkg::issue_t         p;
        logic [`RV_DMEM_AW+2:0] addr;
        p            = rand_issue();
        addr         = {w[`RV_DMEM_AW-1:0], 3'($random(seed)) & (3'b111 << f3[1:0])};
        p.funct3     = f3;
        p.inst_store = store;
        p.inst_load  = ~store;
        p.x_rs1      = 64'({$random(seed)} % 1024);
        p.imm        = 64'(addr) - p.x_rs1;  // base plus offset lands on addr.
        return p;
    endfunction

    task automatic send(rv_pkg::issue_t p);
        issue_valid <= 1'b1;
        issue       <= p;
        @(posedge clk);
        while (!issue_ready) begin
            @(posedge clk);
        end
        exp_q.push_back(ref_model(p));
        issued++;
        if (bp_mode && {$random(seed)} % 4 == 0) begin
            issue_valid <= 1'b0;
            repeat (1 + {$random(seed)} % 3) @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (rst === 1'b1 && retire_valid === 1'b1) begin
            $display("retire_valid went high while reset was asserted");
            $display("TEST FAILED");
            $fatal(1, "retire during reset");
        end else if (retire_valid === 1'b1 && retire_ready === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("a record retired with no instruction outstanding");
                $display("TEST FAILED");
                $fatal(1, "unexpected retire");
            end else begin
                exp_rec = exp_q.pop_front();
                check_retire(retire, exp_rec);
            end
        end
    end

    always @(posedge clk) begin
        retire_ready <= bp_mode ? 1'($random(ready_seed)) : 1'b1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 50 * issued + 200) begin
            $display("watchdog expired after %0d cycles, pipeline stopped retiring", cycles);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rv_pkg::issue_t p;
        int             w;
        seed         = 32'hf5a1eeb1;
        ready_seed   = seed ^ 32'h5a5a_a5a5;  // own stream for retire_ready.
        clk          = 1'b0;
        rst          = 1'b1;
        issue_valid  = 1'b1;  // offered during reset, must not get in.
        issue        = '0;
        retire_ready = 1'b1;
        bp_mode      = 1'b0;
        issued       = 0;
        cycles       = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // all alu ops, both operand sources, some x0 and ebreak records.
        for (int op = 0; op < 10; op++) begin
            for (int k = 0; k < 8; k++) begin
                p         = rand_issue();
                p.alu_op  = rv_pkg::alu_op_e'(op);
                p.use_imm = k[0];
                if (k == 6) p.rd = 5'd0;
                if (k == 7) p.inst_system_ebreak = 1'b1;
                send(p);
            end
        end
        for (w = 0; w < `RV_DMEM_WORDS; w++) begin
            p       = mem_access(1'b1, 3'd3, w);
            p.x_rs2 = {8{w[7:0]}} ^ 64'h0123_4567_89ab_cdef;  // fill by word index.
            send(p);
        end
        for (int k = 0; k < 24; k++) begin
            w = {$random(seed)} % `RV_DMEM_WORDS;
            send(mem_access(1'b1, 3'($random(seed) & 3), w));
            for (int f = 0; f < 7; f++) begin
                send(mem_access(1'b0, 3'(f), w));
            end
        end
        bp_mode <= 1'b1;
        for (int k = 0; k < 150; k++) begin
            w = {$random(seed)} % 8;  // few words so loads see recent stores.
            case ({$random(seed)} % 3)
                0:       p = rand_issue();
                1:       p = mem_access(1'b1, 3'($random(seed) & 3), w);
                default: p = mem_access(1'b0, 3'({$random(seed)} % 7), w);
            endcase
            send(p);
        end
        issue_valid <= 1'b0;
        bp_mode     <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
rv_pkg.sv
pipe_reg.sv
exec_unit.sv
mem_stage.sv
rv_backend.sv
tb_rv_backend_assertions.sv
tb_rv_backend.sv
